/* hw/ddr_pkg.sv */
package ddr_pkg;

	// DDR side, one address per 64-bit word
	localparam int DDR_AW  = 29;
	localparam int DDR_DW  = 64;
	localparam int DDR_BEW = 8;
	localparam int BURST_W = 8;

	// client word addresses
	localparam int CPU_AW  = 18;
	localparam int HALF_AW = 18;

	typedef struct packed {
		logic [DDR_AW-1:0]  addr;
		logic [BURST_W-1:0] burstcnt;
		logic [DDR_DW-1:0]  din;
		logic [DDR_BEW-1:0] be;
		logic               we;
		logic               rd;
	} ddr_cmd_t;

	typedef struct packed {
		logic [DDR_DW-1:0] dout;
		logic              dout_ready;
		logic              busy;
	} ddr_rsp_t;

	typedef struct packed {
		logic [CPU_AW-1:0] addr;
		logic [31:0]       din;
		logic              rd;
		logic [3:0]        wr;
	} cpu_req_t;

	typedef struct packed {
		logic [HALF_AW-1:0] addr;
		logic [15:0]        din;
		logic               rd;
		logic [1:0]         wr;
	} half_req_t;

	// posted write entries
	typedef struct packed {
		logic [CPU_AW-1:0] addr;
		logic [3:0]        be;
		logic [31:0]       data;
	} cpu_wr_t;

	typedef struct packed {
		logic [HALF_AW-1:0] addr;
		logic [1:0]         be;
		logic [15:0]        data;
	} half_wr_t;

	// read beats from the sequencer into a client line
	typedef struct packed {
		logic [DDR_DW-1:0] data;
		logic [2:0]        beat;
		logic              valid;
		logic              last;
	} fill_t;

endpackage

/* hw/write_fifo.sv */
`timescale 1ns/100ps

module write_fifo
	import ddr_pkg::*;
#(
	parameter int  DEPTH_LOG2 = 3,
	parameter type entry_t    = cpu_wr_t
) (
	input  logic   CLK,
	input  logic   RST,
	input  logic   push,
	input  entry_t push_data,
	input  logic   pop,
	output entry_t head,
	output logic   empty,
	output logic   full
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	entry_t mem [DEPTH];

	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;
	logic                  do_push;
	logic                  do_pop;

	assign empty   = (count == '0);
	assign full    = count[DEPTH_LOG2];
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// a push and a pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* hw/client_port.sv */
`timescale 1ns/100ps

module client_port
	import ddr_pkg::*;
#(
	parameter int                DATA_W          = 32,
	parameter int                AW              = 18,
	parameter int                LINE_BEATS      = 4,
	parameter int                FIFO_DEPTH_LOG2 = 3,
	parameter logic [DDR_AW-1:0] REGION_BASE     = '0,
	parameter type               wr_entry_t      = cpu_wr_t
) (
	input  logic                CLK,
	input  logic                RST,
	input  logic [AW-1:0]       addr,
	input  logic [DATA_W-1:0]   din,
	input  logic                rd,
	input  logic [DATA_W/8-1:0] wr,
	output logic [DATA_W-1:0]   dout,
	output logic                busy,
	output logic                wr_req,
	output ddr_cmd_t            wr_cmd,
	output logic                rd_req,
	output ddr_cmd_t            rd_cmd,
	input  logic                wr_ack,
	input  fill_t               fill
);

	localparam int LANES    = DDR_DW / DATA_W;
	localparam int LANE_W   = $clog2(LANES);
	localparam int BPL      = DATA_W / 8;
	localparam int BEAT_W   = $clog2(LINE_BEATS);
	localparam int LINE_LSB = LANE_W + BEAT_W;

	logic rd_old;
	logic wr_old;
	logic rd_edge;
	logic wr_edge;

	// read line state
	logic [AW-1:0] rc_addr;
	logic          rc_dirty;
	logic          fetch_pending;

	logic [DDR_DW-1:0] line_mem [LINE_BEATS];
	logic [DDR_DW-1:0] line_q;
	logic [AW-1:0]     line_base;

	wr_entry_t push_entry;
	wr_entry_t head;
	logic      fifo_empty;
	logic      fifo_full;
	logic [LANE_W-1:0] wr_lane;

	assign rd_edge = rd && !rd_old;
	assign wr_edge = (|wr) && !wr_old;

	always_ff @(posedge CLK) begin
		if (RST) begin
			rd_old <= 1'b0;
			wr_old <= 1'b0;
		end else begin
			rd_old <= rd;
			wr_old <= |wr;
		end
	end

	always_ff @(posedge CLK) begin
		if (RST) begin
			rc_dirty      <= 1'b1;
			fetch_pending <= 1'b0;
		end else begin
			if (rd_edge) begin
				if (addr[AW-1:LINE_LSB] != rc_addr[AW-1:LINE_LSB] || rc_dirty) begin
					fetch_pending <= 1'b1;
				end
				rc_dirty <= 1'b0;
			end
			// writing into the held line makes it stale
			if (wr_edge && addr[AW-1:LINE_LSB] == rc_addr[AW-1:LINE_LSB]) begin
				rc_dirty <= 1'b1;
			end
			if (fill.valid && fill.last) begin
				fetch_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_edge) begin
			rc_addr <= addr;
		end
		if (fill.valid) begin
			line_mem[fill.beat[BEAT_W-1:0]] <= fill.data;
		end
	end

	// lane 0 sits in the upper half of the word
	assign line_q = line_mem[rc_addr[LINE_LSB-1:LANE_W]];
	assign dout   = line_q[(LANES - 1 - rc_addr[LANE_W-1:0]) * DATA_W +: DATA_W];
	assign busy   = fifo_full || fetch_pending;

	always_comb begin
		push_entry.addr = addr;
		push_entry.be   = wr;
		push_entry.data = din;
	end

	write_fifo #(
		.DEPTH_LOG2(FIFO_DEPTH_LOG2),
		.entry_t   (wr_entry_t)
	) wr_fifo (
		.CLK      (CLK),
		.RST      (RST),
		.push     (wr_edge),
		.push_data(push_entry),
		.pop      (wr_ack),
		.head     (head),
		.empty    (fifo_empty),
		.full     (fifo_full)
	);

	assign wr_lane = head.addr[LANE_W-1:0];
	assign wr_req  = !fifo_empty;

	always_comb begin
		wr_cmd.addr     = REGION_BASE + DDR_AW'(head.addr >> LANE_W);
		wr_cmd.burstcnt = BURST_W'(1);
		wr_cmd.din      = {LANES{head.data}};
		wr_cmd.be       = DDR_BEW'(head.be) << ((LANES - 1 - wr_lane) * BPL);
		wr_cmd.we       = 1'b1;
		wr_cmd.rd       = 1'b0;
	end

	assign line_base = {rc_addr[AW-1:LINE_LSB], {LINE_LSB{1'b0}}};
	assign rd_req    = fetch_pending;

	always_comb begin
		rd_cmd.addr     = REGION_BASE + DDR_AW'(line_base >> LANE_W);
		rd_cmd.burstcnt = BURST_W'(LINE_BEATS);
		rd_cmd.din      = '0;
		rd_cmd.be       = '1;
		rd_cmd.we       = 1'b0;
		rd_cmd.rd       = 1'b1;
	end

endmodule

/* hw/burst_counter.sv */
`timescale 1ns/100ps

module burst_counter
	import ddr_pkg::*;
(
	input  logic               CLK,
	input  logic               RST,
	input  logic               start,
	input  logic [BURST_W-1:0] len,
	input  logic               beat_en,
	output logic [2:0]         beat,
	output logic               last
);

	logic [BURST_W-1:0] len_q;

	always_ff @(posedge CLK) begin
		if (RST) begin
			beat  <= '0;
			len_q <= '0;
		end else if (start) begin
			beat  <= '0;
			len_q <= len;
		end else if (beat_en) begin
			beat <= beat + 1'b1;
		end
	end

	// flags the final beat of the burst while it is on the bus
	assign last = (BURST_W'(beat) == len_q - 1'b1);

endmodule

/* hw/ddr_sequencer.sv */
`timescale 1ns/100ps

module ddr_sequencer
	import ddr_pkg::*;
(
	input  logic               CLK,
	input  logic               RST,
	input  ddr_rsp_t           ddr_rsp,
	output ddr_cmd_t           ddr_cmd,
	input  logic               cpu_wr_req,
	input  ddr_cmd_t           cpu_wr_cmd,
	input  logic               cpu_rd_req,
	input  ddr_cmd_t           cpu_rd_cmd,
	input  logic               half_wr_req,
	input  ddr_cmd_t           half_wr_cmd,
	input  logic               half_rd_req,
	input  ddr_cmd_t           half_rd_cmd,
	output logic               cpu_wr_ack,
	output logic               half_wr_ack,
	output fill_t              cpu_fill,
	output fill_t              half_fill,
	input  logic [2:0]         beat,
	input  logic               last,
	output logic               start,
	output logic [BURST_W-1:0] len,
	output logic               beat_en
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_POST_WR,
		S_FILL
	} state_t;

	typedef enum logic [2:0] {
		PICK_NONE,
		PICK_CPU_WR,
		PICK_CPU_RD,
		PICK_HALF_WR,
		PICK_HALF_RD
	} pick_t;

	state_t   state;
	pick_t    pick;
	ddr_cmd_t cmd_q;
	logic     sel_half;

	// fixed priority, only taken from idle in a free cycle
	always_comb begin
		pick = PICK_NONE;
		if (state == S_IDLE && !ddr_rsp.busy) begin
			if (cpu_wr_req) begin
				pick = PICK_CPU_WR;
			end else if (cpu_rd_req) begin
				pick = PICK_CPU_RD;
			end else if (half_wr_req) begin
				pick = PICK_HALF_WR;
			end else if (half_rd_req) begin
				pick = PICK_HALF_RD;
			end
		end
	end

	assign cpu_wr_ack  = (pick == PICK_CPU_WR);
	assign half_wr_ack = (pick == PICK_HALF_WR);
	assign start       = (pick == PICK_CPU_RD) || (pick == PICK_HALF_RD);
	assign len         = (pick == PICK_HALF_RD) ? half_rd_cmd.burstcnt : cpu_rd_cmd.burstcnt;
	assign beat_en     = (state == S_FILL) && ddr_rsp.dout_ready && !ddr_rsp.busy;

	always_ff @(posedge CLK) begin
		if (RST) begin
			state    <= S_IDLE;
			sel_half <= 1'b0;
			cmd_q.we <= 1'b0;
			cmd_q.rd <= 1'b0;
		end else if (!ddr_rsp.busy) begin
			cmd_q.we <= 1'b0;
			cmd_q.rd <= 1'b0;
			case (state)
				S_IDLE: begin
					case (pick)
						PICK_CPU_WR: begin
							cmd_q <= cpu_wr_cmd;
							state <= S_POST_WR;
						end
						PICK_CPU_RD: begin
							cmd_q    <= cpu_rd_cmd;
							sel_half <= 1'b0;
							state    <= S_FILL;
						end
						PICK_HALF_WR: begin
							cmd_q <= half_wr_cmd;
							state <= S_POST_WR;
						end
						PICK_HALF_RD: begin
							cmd_q    <= half_rd_cmd;
							sel_half <= 1'b1;
							state    <= S_FILL;
						end
						default: begin
							state <= S_IDLE;
						end
					endcase
				end
				S_POST_WR: begin
					state <= S_IDLE;
				end
				S_FILL: begin
					if (beat_en && last) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	assign ddr_cmd = cmd_q;

	always_comb begin
		cpu_fill.data  = ddr_rsp.dout;
		cpu_fill.beat  = beat;
		cpu_fill.last  = last;
		half_fill.data = ddr_rsp.dout;
		half_fill.beat = beat;
		half_fill.last = last;

		// beats only reach the client that asked for the line
		cpu_fill.valid  = beat_en && !sel_half;
		half_fill.valid = beat_en && sel_half;
	end

endmodule

/* hw/ddr_arbiter_top.sv */
`timescale 1ns/100ps

module ddr_arbiter_top
	import ddr_pkg::*;
(
	input  logic        CLK,
	input  logic        RST,
	input  cpu_req_t    cpu_req,
	output logic [31:0] cpu_dout,
	output logic        cpu_busy,
	input  half_req_t   half_req,
	output logic [15:0] half_dout,
	output logic        half_busy,
	output ddr_cmd_t    ddr_cmd,
	input  ddr_rsp_t    ddr_rsp
);

	logic     cpu_wr_req;
	ddr_cmd_t cpu_wr_cmd;
	logic     cpu_rd_req;
	ddr_cmd_t cpu_rd_cmd;
	logic     cpu_wr_ack;
	fill_t    cpu_fill;

	logic     half_wr_req;
	ddr_cmd_t half_wr_cmd;
	logic     half_rd_req;
	ddr_cmd_t half_rd_cmd;
	logic     half_wr_ack;
	fill_t    half_fill;

	logic               start;
	logic [BURST_W-1:0] len;
	logic               beat_en;
	logic [2:0]         beat;
	logic               last;

	client_port #(
		.DATA_W         (32),
		.AW             (CPU_AW),
		.LINE_BEATS     (4),
		.FIFO_DEPTH_LOG2(3),
		.REGION_BASE    (29'h0600000),
		.wr_entry_t     (cpu_wr_t)
	) cpu_port (
		.CLK   (CLK),
		.RST   (RST),
		.addr  (cpu_req.addr),
		.din   (cpu_req.din),
		.rd    (cpu_req.rd),
		.wr    (cpu_req.wr),
		.dout  (cpu_dout),
		.busy  (cpu_busy),
		.wr_req(cpu_wr_req),
		.wr_cmd(cpu_wr_cmd),
		.rd_req(cpu_rd_req),
		.rd_cmd(cpu_rd_cmd),
		.wr_ack(cpu_wr_ack),
		.fill  (cpu_fill)
	);

	client_port #(
		.DATA_W         (16),
		.AW             (HALF_AW),
		.LINE_BEATS     (2),
		.FIFO_DEPTH_LOG2(2),
		.REGION_BASE    (29'h0800000),
		.wr_entry_t     (half_wr_t)
	) half_port (
		.CLK   (CLK),
		.RST   (RST),
		.addr  (half_req.addr),
		.din   (half_req.din),
		.rd    (half_req.rd),
		.wr    (half_req.wr),
		.dout  (half_dout),
		.busy  (half_busy),
		.wr_req(half_wr_req),
		.wr_cmd(half_wr_cmd),
		.rd_req(half_rd_req),
		.rd_cmd(half_rd_cmd),
		.wr_ack(half_wr_ack),
		.fill  (half_fill)
	);

	ddr_sequencer seq (
		.CLK        (CLK),
		.RST        (RST),
		.ddr_rsp    (ddr_rsp),
		.ddr_cmd    (ddr_cmd),
		.cpu_wr_req (cpu_wr_req),
		.cpu_wr_cmd (cpu_wr_cmd),
		.cpu_rd_req (cpu_rd_req),
		.cpu_rd_cmd (cpu_rd_cmd),
		.half_wr_req(half_wr_req),
		.half_wr_cmd(half_wr_cmd),
		.half_rd_req(half_rd_req),
		.half_rd_cmd(half_rd_cmd),
		.cpu_wr_ack (cpu_wr_ack),
		.half_wr_ack(half_wr_ack),
		.cpu_fill   (cpu_fill),
		.half_fill  (half_fill),
		.beat       (beat),
		.last       (last),
		.start      (start),
		.len        (len),
		.beat_en    (beat_en)
	);

	burst_counter counter (
		.CLK    (CLK),
		.RST    (RST),
		.start  (start),
		.len    (len),
		.beat_en(beat_en),
		.beat   (beat),
		.last   (last)
	);

endmodule

/* tb/ddr_mem_model.sv */
`timescale 1ns/100ps

module ddr_mem_model
	import ddr_pkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  ddr_cmd_t ddr_cmd,
	output ddr_rsp_t ddr_rsp,
	input  logic     force_busy,
	input  logic     rand_busy
);

	// sparse storage, only written words are kept
	logic [DDR_AW-1:0] keys [$];
	logic [DDR_DW-1:0] vals [$];

	logic [DDR_AW-1:0]  next_addr;
	logic [BURST_W-1:0] beats_left;
	logic [DDR_DW-1:0]  dout_q;
	logic               busy_q;
	int                 seed = 9;

	function automatic int find_word(input logic [DDR_AW-1:0] a);
		for (int i = 0; i < keys.size(); i++) begin
			if (keys[i] == a) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic logic [DDR_DW-1:0] peek(input logic [DDR_AW-1:0] a);
		int idx;
		idx = find_word(a);
		if (idx >= 0) begin
			return vals[idx];
		end
		// unwritten words read as their own address
		return {3'b000, a, 3'b000, a};
	endfunction

	function automatic logic [DDR_DW-1:0] merge_bytes(
		input logic [DDR_DW-1:0]  old,
		input logic [DDR_DW-1:0]  din,
		input logic [DDR_BEW-1:0] be
	);
		logic [DDR_DW-1:0] w;
		w = old;
		for (int i = 0; i < DDR_BEW; i++) begin
			if (be[i]) begin
				w[i*8 +: 8] = din[i*8 +: 8];
			end
		end
		return w;
	endfunction

	task automatic store_word(input logic [DDR_AW-1:0] a, input logic [DDR_DW-1:0] w);
		int idx;
		idx = find_word(a);
		if (idx < 0) begin
			keys.push_back(a);
			vals.push_back(w);
		end else begin
			vals[idx] = w;
		end
	endtask

	always @(posedge CLK) begin
		if (RST) begin
			beats_left <= '0;
			next_addr  <= '0;
			dout_q     <= '0;
			busy_q     <= 1'b0;
		end else begin
			busy_q <= force_busy || (rand_busy && (($random(seed) & 3) == 0));
			if (!busy_q) begin
				// beat on the bus is taken, present the next one
				if (beats_left != '0) begin
					beats_left <= beats_left - 1'b1;
					dout_q     <= peek(next_addr);
					next_addr  <= next_addr + 1'b1;
				end
				if (ddr_cmd.we) begin
					store_word(ddr_cmd.addr,
						merge_bytes(peek(ddr_cmd.addr), ddr_cmd.din, ddr_cmd.be));
				end
				if (ddr_cmd.rd) begin
					beats_left <= ddr_cmd.burstcnt;
					dout_q     <= peek(ddr_cmd.addr);
					next_addr  <= ddr_cmd.addr + 1'b1;
				end
			end
		end
	end

	assign ddr_rsp = {dout_q, beats_left != '0, busy_q};

endmodule

/* tb/tb_ddr_arbiter.sv */
`timescale 1ns/100ps

module tb_ddr_arbiter
	import ddr_pkg::*;
();

	localparam logic [DDR_AW-1:0]  CPU_BASE  = 29'h0600000;
	localparam logic [DDR_AW-1:0]  HALF_BASE = 29'h0800000;
	localparam logic [CPU_AW-1:0]  CPU_ADDR  = 18'h00124;
	localparam logic [CPU_AW-1:0]  BP_ADDR   = 18'h00200;
	localparam logic [HALF_AW-1:0] HALF_ADDR = 18'h00100;
	localparam int                 TIMEOUT   = 500;

	logic        CLK;
	logic        RST;
	cpu_req_t    cpu_req;
	logic [31:0] cpu_dout;
	logic        cpu_busy;
	half_req_t   half_req;
	logic [15:0] half_dout;
	logic        half_busy;
	ddr_cmd_t    ddr_cmd;
	ddr_rsp_t    ddr_rsp;
	logic        force_busy;
	logic        rand_busy;

	int errors;
	int tests;
	int test_base;

	// expected DDR contents, built from the writes issued here
	logic [DDR_AW-1:0] exp_keys [$];
	logic [63:0]       exp_vals [$];

	ddr_arbiter_top uut (
		.CLK      (CLK),
		.RST      (RST),
		.cpu_req  (cpu_req),
		.cpu_dout (cpu_dout),
		.cpu_busy (cpu_busy),
		.half_req (half_req),
		.half_dout(half_dout),
		.half_busy(half_busy),
		.ddr_cmd  (ddr_cmd),
		.ddr_rsp  (ddr_rsp)
	);

	ddr_mem_model ddr (
		.CLK       (CLK),
		.RST       (RST),
		.ddr_cmd   (ddr_cmd),
		.ddr_rsp   (ddr_rsp),
		.force_busy(force_busy),
		.rand_busy (rand_busy)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic step_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%0t: %s finished with %0d errors", $time, name, errors - test_base);
		test_base = errors;
	endtask

	function automatic logic [63:0] expected_word(input logic [DDR_AW-1:0] a);
		for (int i = 0; i < exp_keys.size(); i++) begin
			if (exp_keys[i] == a) begin
				return exp_vals[i];
			end
		end
		return {3'b000, a, 3'b000, a};
	endfunction

	// lane 0 is the most significant lane of the 64-bit word
	task automatic record_write(input logic [DDR_AW-1:0] a, input int lane, input int lanes,
		input logic [31:0] d, input logic [3:0] be);
		logic [63:0] w;
		int          width;
		int          idx;
		w     = expected_word(a);
		width = 64 / lanes;
		idx   = -1;
		for (int b = 0; b < width / 8; b++) begin
			if (be[b]) begin
				w[(lanes - 1 - lane) * width + b * 8 +: 8] = d[b*8 +: 8];
			end
		end
		for (int i = 0; i < exp_keys.size(); i++) begin
			if (exp_keys[i] == a) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			exp_keys.push_back(a);
			exp_vals.push_back(w);
		end else begin
			exp_vals[idx] = w;
		end
	endtask

	function automatic logic [31:0] lane_value(input logic [DDR_AW-1:0] a, input int lane,
		input int lanes);
		logic [63:0] w;
		int          width;
		width = 64 / lanes;
		w     = expected_word(a) >> ((lanes - 1 - lane) * width);
		if (width == 16) begin
			return {16'h0000, w[15:0]};
		end
		return w[31:0];
	endfunction

	task automatic cpu_write(input logic [CPU_AW-1:0] a, input logic [31:0] d,
		input logic [3:0] be);
		int n;
		n = 0;
		while (cpu_busy && n < TIMEOUT) begin
			step_cycle();
			n++;
		end
		if (cpu_busy) begin
			$display("%0t: cpu_busy never fell before a write to %h", $time, a);
			errors++;
		end
		cpu_req.addr = a;
		cpu_req.din  = d;
		cpu_req.wr   = be;
		step_cycle();
		cpu_req.wr = '0;
		step_cycle();
		record_write(CPU_BASE + (a >> 1), a[0], 2, d, be);
	endtask

	task automatic half_write(input logic [HALF_AW-1:0] a, input logic [15:0] d,
		input logic [1:0] be);
		int n;
		n = 0;
		while (half_busy && n < TIMEOUT) begin
			step_cycle();
			n++;
		end
		if (half_busy) begin
			$display("%0t: half_busy never fell before a write to %h", $time, a);
			errors++;
		end
		half_req.addr = a;
		half_req.din  = d;
		half_req.wr   = be;
		step_cycle();
		half_req.wr = '0;
		step_cycle();
		record_write(HALF_BASE + (a >> 2), a[1:0], 4, {16'h0000, d}, {2'b00, be});
	endtask

	task automatic cpu_read(input logic [CPU_AW-1:0] a, output logic [31:0] d,
		output logic busy_seen);
		int n;
		cpu_req.addr = a;
		cpu_req.rd   = 1'b1;
		step_cycle();
		cpu_req.rd = 1'b0;
		busy_seen  = cpu_busy;
		n = 0;
		while (cpu_busy && n < TIMEOUT) begin
			step_cycle();
			n++;
		end
		if (cpu_busy) begin
			$display("%0t: cpu read of %h never finished, cpu_busy stuck high", $time, a);
			errors++;
		end
		d = cpu_dout;
		// rd must be seen low at an edge before the next read
		step_cycle();
	endtask

	task automatic half_read(input logic [HALF_AW-1:0] a, output logic [15:0] d,
		output logic busy_seen);
		int n;
		half_req.addr = a;
		half_req.rd   = 1'b1;
		step_cycle();
		half_req.rd = 1'b0;
		busy_seen   = half_busy;
		n = 0;
		while (half_busy && n < TIMEOUT) begin
			step_cycle();
			n++;
		end
		if (half_busy) begin
			$display("%0t: half read of %h never finished, half_busy stuck high", $time, a);
			errors++;
		end
		d = half_dout;
		step_cycle();
	endtask

	task automatic check_reset();
		check_value("ddr_cmd.we", ddr_cmd.we, 1'b0);
		check_value("ddr_cmd.rd", ddr_cmd.rd, 1'b0);
		check_value("cpu_busy", cpu_busy, 1'b0);
		check_value("half_busy", half_busy, 1'b0);
		end_test("reset");
	endtask

	task automatic cpu_write_read();
		logic [31:0] d;
		logic        b;
		cpu_write(CPU_ADDR, 32'hDEADBEEF, 4'hF);
		cpu_read(CPU_ADDR, d, b);
		check_value("cpu_dout", d, lane_value(CPU_BASE + (CPU_ADDR >> 1), CPU_ADDR[0], 2));
		check_value("ddr word", ddr.peek(CPU_BASE + (CPU_ADDR >> 1)),
			expected_word(CPU_BASE + (CPU_ADDR >> 1)));
		end_test("cpu write then read");
	endtask

	task automatic half_byte_merge();
		logic [15:0] d;
		logic        b;
		logic [HALF_AW-1:0] a;
		// one byte per lane, the other byte of din must be masked off
		half_write(HALF_ADDR + 18'd0, 16'h5AFF, 2'b10);
		half_write(HALF_ADDR + 18'd1, 16'hFFC3, 2'b01);
		half_write(HALF_ADDR + 18'd2, 16'h96FF, 2'b10);
		half_write(HALF_ADDR + 18'd3, 16'hFF17, 2'b01);
		for (int i = 0; i < 4; i++) begin
			a = HALF_ADDR + 18'(i);
			half_read(a, d, b);
			check_value("half_dout", d, lane_value(HALF_BASE + (a >> 2), a[1:0], 4));
		end
		check_value("ddr word", ddr.peek(HALF_BASE + (HALF_ADDR >> 2)),
			expected_word(HALF_BASE + (HALF_ADDR >> 2)));
		end_test("half partial writes");
	endtask

	task automatic hit_and_invalidate();
		logic [31:0]       d;
		logic              b;
		logic [CPU_AW-1:0] a;
		a = CPU_ADDR + 18'd1;
		cpu_read(a, d, b);
		check_value("cpu_busy", b, 1'b0);
		check_value("cpu_dout", d, lane_value(CPU_BASE + (a >> 1), a[0], 2));
		a = CPU_ADDR + 18'd2;
		cpu_write(a, 32'h0BADF00D, 4'b0011);
		cpu_read(a, d, b);
		check_value("cpu_busy", b, 1'b1);
		check_value("cpu_dout", d, lane_value(CPU_BASE + (a >> 1), a[0], 2));
		end_test("hit and invalidation");
	endtask

	task automatic back_pressure();
		logic [31:0]        d;
		logic [15:0]        hd;
		logic               b;
		logic [CPU_AW-1:0]  a;
		logic [HALF_AW-1:0] ha;
		int                 accepted;
		force_busy = 1'b1;
		step_cycle();
		step_cycle();
		accepted = 0;
		// the sequencer is frozen, so the FIFO fills until busy rises
		while (!cpu_busy && accepted < 12) begin
			cpu_write(BP_ADDR + 18'(accepted % 6), 32'hC0DE0000 + 32'(accepted), 4'hF);
			accepted++;
		end
		check_value("cpu_busy", cpu_busy, 1'b1);
		check_value("accepted writes", accepted, 8);
		force_busy = 1'b0;
		rand_busy  = 1'b1;
		for (int k = 0; k < 6; k++) begin
			a = BP_ADDR + 18'(k);
			cpu_read(a, d, b);
			check_value("cpu_dout", d, lane_value(CPU_BASE + (a >> 1), a[0], 2));
			if (k < 3) begin
				ha = HALF_ADDR + 18'(8 * k);
				half_read(ha, hd, b);
				check_value("half_dout", hd, lane_value(HALF_BASE + (ha >> 2), ha[1:0], 4));
			end
		end
		for (int k = 0; k < 3; k++) begin
			check_value("ddr word", ddr.peek(CPU_BASE + (BP_ADDR >> 1) + 29'(k)),
				expected_word(CPU_BASE + (BP_ADDR >> 1) + 29'(k)));
		end
		rand_busy = 1'b0;
		end_test("back-pressure");
	endtask

	initial begin
		errors     = 0;
		tests      = 0;
		test_base  = 0;
		RST        = 1'b1;
		cpu_req    = '0;
		half_req   = '0;
		force_busy = 1'b0;
		rand_busy  = 1'b0;
		repeat (5) @(posedge CLK);
		#1;
		RST = 1'b0;

		check_reset();
		cpu_write_read();
		half_byte_merge();
		hit_and_invalidate();
		back_pressure();

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* ddr_arbiter.f */
hw/ddr_pkg.sv
hw/write_fifo.sv
hw/client_port.sv
hw/burst_counter.sv
hw/ddr_sequencer.sv
hw/ddr_arbiter_top.sv
tb/ddr_mem_model.sv
tb/tb_ddr_arbiter.sv

/* Bender.yml */
package:
  name: ddr_arbiter

sources:
  - files:
      - hw/ddr_pkg.sv
      - hw/write_fifo.sv
      - hw/client_port.sv
      - hw/burst_counter.sv
      - hw/ddr_sequencer.sv
      - hw/ddr_arbiter_top.sv
  - target: test
    files:
      - tb/ddr_mem_model.sv
      - tb/tb_ddr_arbiter.sv
